/* logic/wasm_f32_pkg.sv */
// IEEE 754 single-precision format definitions
// Field types, operand class flags and special bit patterns

`default_nettype none

package wasm_f32_pkg;

    // Raw single-precision value
    // [31] sign, [30:23] biased exponent, [22:0] stored mantissa
    typedef logic [31:0] f32_t;

    // Biased exponent field
    typedef logic [7:0] f32_exp_t;

    // Stored mantissa field, implicit leading one not included
    typedef logic [22:0] f32_mant_t;

    // Operand classification needed by the sign and compare operations
    typedef struct packed {
        logic is_zero;
        logic is_nan;
    } f32_class_t;

    // Exponent value shared by infinities and NaNs
    localparam f32_exp_t F32_EXP_MAX = 8'hFF;

    // Quiet NaN returned by min and max
    localparam f32_t F32_CANONICAL_NAN = 32'h7FC0_0000;

endpackage

`default_nettype wire

/* logic/wasm_fpu_pkg.sv */
// Operation set and pipeline payload types of the f32 bit-pattern unit
// Request, staged request and result word shared by all stages

`default_nettype none

package wasm_fpu_pkg;

    import wasm_f32_pkg::*;

    // Supported operations
    // Codes 11 to 15 are unused and give a zero result
    typedef enum logic [3:0] {
        FPU_ABS      = 4'd0,
        FPU_NEG      = 4'd1,
        FPU_COPYSIGN = 4'd2,
        FPU_MIN      = 4'd3,
        FPU_MAX      = 4'd4,
        FPU_EQ       = 4'd5,
        FPU_NE       = 4'd6,
        FPU_LT       = 4'd7,
        FPU_GT       = 4'd8,
        FPU_LE       = 4'd9,
        FPU_GE       = 4'd10
    } fpu_op_t;

    // Result word, either an f32 value or an i32 truth value
    typedef logic [31:0] word_t;

    // Request as presented on the input channel
    typedef struct packed {
        fpu_op_t op;
        f32_t    a;
        f32_t    b;
    } fpu_req_t;

    // Request after the issue stage, with both operands classified
    typedef struct packed {
        fpu_req_t   req;
        f32_class_t class_a;
        f32_class_t class_b;
    } fpu_staged_t;

endpackage

`default_nettype wire

/* logic/fpu_order_unit.sv */
// IEEE ordering of two f32 values on their sign-magnitude patterns
// Gives the equal and less-than relations, NaN operands are unordered

`default_nettype none
`timescale 1ns/100ps

module fpu_order_unit (
    input  wasm_f32_pkg::f32_t       a,
    input  wasm_f32_pkg::f32_t       b,
    input  wasm_f32_pkg::f32_class_t class_a,
    input  wasm_f32_pkg::f32_class_t class_b,
    output logic                     eq,
    output logic                     lt
);

    logic        unordered;
    logic        both_zero;
    logic        sign_a;
    logic        sign_b;
    logic [30:0] mag_a;
    logic [30:0] mag_b;
    logic        mag_lt;
    logic        mag_gt;
    logic        sign_lt;

    assign sign_a = a[31];
    assign sign_b = b[31];
    assign mag_a  = a[30:0];
    assign mag_b  = b[30:0];

    assign unordered = class_a.is_nan || class_b.is_nan;

    // +0 and -0 compare equal whatever their signs
    assign both_zero = class_a.is_zero && class_b.is_zero;

    assign mag_lt = mag_a < mag_b;
    assign mag_gt = mag_a > mag_b;

    // Same sign: magnitude order, reversed for negatives
    // Mixed sign: the negative operand is the lesser one
    always_comb begin
        if (sign_a != sign_b) begin
            sign_lt = sign_a;
        end else if (sign_a) begin
            sign_lt = mag_gt;
        end else begin
            sign_lt = mag_lt;
        end
    end

    assign eq = !unordered && (both_zero || (a == b));
    assign lt = !unordered && !both_zero && sign_lt;

endmodule

`default_nettype wire

/* logic/fpu_issue_stage.sv */
// First pipeline stage of the f32 unit
// Accepts requests, classifies both operands and registers them

`default_nettype none
`timescale 1ns/100ps

module fpu_issue_stage (
    input  logic                      clk,
    input  logic                      arst_n,

    // Request channel
    input  logic                      in_valid,
    output logic                      in_ready,
    input  wasm_fpu_pkg::fpu_req_t    req,

    // Staged channel towards the execute stage
    output logic                      s1_valid,
    input  logic                      s1_ready,
    output wasm_fpu_pkg::fpu_staged_t s1
);

    import wasm_f32_pkg::*;
    import wasm_fpu_pkg::*;

    f32_class_t class_a;
    f32_class_t class_b;

    // Zero and NaN detection on the raw bit pattern
    function automatic f32_class_t classify(input f32_t value);
        f32_exp_t   exp_f;
        f32_mant_t  mant_f;
        f32_class_t cls;

        exp_f       = value[30:23];
        mant_f      = value[22:0];
        cls.is_zero = (exp_f == '0) && (mant_f == '0);
        cls.is_nan  = (exp_f == F32_EXP_MAX) && (mant_f != '0);
        return cls;
    endfunction

    assign class_a = classify(req.a);
    assign class_b = classify(req.b);

    // Register is free when empty or when its content leaves this cycle
    assign in_ready = !s1_valid || s1_ready;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            s1_valid <= 1'b0;
        end else if (in_ready) begin
            s1_valid <= in_valid;
        end
    end

    // Payload follows the valid flag, content is don't-care while empty
    always_ff @(posedge clk) begin
        if (in_ready) begin
            s1.req     <= req;
            s1.class_a <= class_a;
            s1.class_b <= class_b;
        end
    end

endmodule

`default_nettype wire

/* logic/fpu_exec_stage.sv */
// Second pipeline stage of the f32 unit
// Selects the result per operation and holds it in the output register

`default_nettype none
`timescale 1ns/100ps

module fpu_exec_stage (
    input  logic                      clk,
    input  logic                      arst_n,

    // Staged channel from the issue stage
    input  logic                      s1_valid,
    output logic                      s1_ready,
    input  wasm_fpu_pkg::fpu_staged_t s1,

    // Result channel
    output logic                      out_valid,
    input  logic                      out_ready,
    output wasm_fpu_pkg::word_t       result
);

    import wasm_f32_pkg::*;
    import wasm_fpu_pkg::*;

    f32_t       a;
    f32_t       b;
    f32_class_t class_a;
    f32_class_t class_b;
    logic       eq_ab;
    logic       lt_ab;
    logic       eq_ba;
    logic       gt_ab;
    logic       any_nan;
    logic       both_zero;
    f32_t       min_val;
    f32_t       max_val;
    word_t      result_d;

    assign a       = s1.req.a;
    assign b       = s1.req.b;
    assign class_a = s1.class_a;
    assign class_b = s1.class_b;

    fpu_order_unit u_order_ab (
        .a       (a),
        .b       (b),
        .class_a (class_a),
        .class_b (class_b),
        .eq      (eq_ab),
        .lt      (lt_ab)
    );

    // Swapped operands, so lt here means a > b
    fpu_order_unit u_order_ba (
        .a       (b),
        .b       (a),
        .class_a (class_b),
        .class_b (class_a),
        .eq      (eq_ba),
        .lt      (gt_ab)
    );

    assign any_nan   = class_a.is_nan || class_b.is_nan;
    assign both_zero = class_a.is_zero && class_b.is_zero;

    // Equal operands give b, signed zeros pick by sign
    always_comb begin
        if (any_nan) begin
            min_val = F32_CANONICAL_NAN;
            max_val = F32_CANONICAL_NAN;
        end else if (both_zero) begin
            min_val = a[31] ? a : b;
            max_val = a[31] ? b : a;
        end else begin
            min_val = lt_ab ? a : b;
            max_val = gt_ab ? a : b;
        end
    end

    always_comb begin
        case (s1.req.op)
            FPU_ABS:      result_d = {1'b0, a[30:0]};
            FPU_NEG:      result_d = {~a[31], a[30:0]};
            FPU_COPYSIGN: result_d = {b[31], a[30:0]};
            FPU_MIN:      result_d = min_val;
            FPU_MAX:      result_d = max_val;
            FPU_EQ:       result_d = {31'b0, eq_ab};
            FPU_NE:       result_d = {31'b0, !eq_ab};
            FPU_LT:       result_d = {31'b0, lt_ab};
            FPU_GT:       result_d = {31'b0, gt_ab};
            FPU_LE:       result_d = {31'b0, lt_ab || eq_ab};
            // a >= b is b <= a
            FPU_GE:       result_d = {31'b0, gt_ab || eq_ba};
            default:      result_d = '0;
        endcase
    end

    // Output register accepts when empty or when it drains this cycle
    assign s1_ready = !out_valid || out_ready;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
        end else if (s1_ready) begin
            out_valid <= s1_valid;
        end
    end

    // Loads only on a transfer, so result holds while stalled
    always_ff @(posedge clk) begin
        if (s1_valid && s1_ready) begin
            result <= result_d;
        end
    end

endmodule

`default_nettype wire

/* logic/wasm_fpu_f32.sv */
// Top level of the pipelined WebAssembly f32 sign, compare and min/max unit
// Issue stage followed by execute stage, two cycles of latency

`default_nettype none
`timescale 1ns/100ps

module wasm_fpu_f32 (
    input  logic                   clk,
    input  logic                   arst_n,

    // Request channel
    input  logic                   in_valid,
    output logic                   in_ready,
    input  wasm_fpu_pkg::fpu_req_t req,

    // Result channel
    output logic                   out_valid,
    input  logic                   out_ready,
    output wasm_fpu_pkg::word_t    result
);

    import wasm_fpu_pkg::*;

    // Staged channel between the two pipeline stages
    logic        s1_valid;
    logic        s1_ready;
    fpu_staged_t s1;

    fpu_issue_stage u_issue (
        .clk      (clk),
        .arst_n   (arst_n),
        .in_valid (in_valid),
        .in_ready (in_ready),
        .req      (req),
        .s1_valid (s1_valid),
        .s1_ready (s1_ready),
        .s1       (s1)
    );

    fpu_exec_stage u_exec (
        .clk       (clk),
        .arst_n    (arst_n),
        .s1_valid  (s1_valid),
        .s1_ready  (s1_ready),
        .s1        (s1),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .result    (result)
    );

endmodule

`default_nettype wire

/* verif/wasm_fpu_f32_chk.sv */
// Handshake and reset assertions for the f32 unit
// Attached to the top level by bind

`default_nettype none
`timescale 1ns/100ps

module wasm_fpu_f32_chk (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   in_valid,
    input  logic                   in_ready,
    input  wasm_fpu_pkg::fpu_req_t req,
    input  logic                   out_valid,
    input  logic                   out_ready,
    input  wasm_fpu_pkg::word_t    result
);

    // Number of assertion failures so far, read by the testbench
    int assert_errors = 0;

    // Nothing leaves the unit while reset is held
    a_reset_quiet: assert property (@(posedge clk) !arst_n |-> !out_valid)
        else begin
            assert_errors++;
            $error("out_valid high while reset is active");
        end

    // Stalled result holds until taken
    a_result_hold: assert property (@(posedge clk) disable iff (!arst_n)
        out_valid && !out_ready |=> out_valid && $stable(result))
        else begin
            assert_errors++;
            $error("out_valid or result changed while out_ready was low");
        end

    // Source side of the request channel
    a_request_hold: assert property (@(posedge clk) disable iff (!arst_n)
        in_valid && !in_ready |=> in_valid && $stable(req))
        else begin
            assert_errors++;
            $error("in_valid or req changed before the request was accepted");
        end

endmodule

bind wasm_fpu_f32 wasm_fpu_f32_chk u_chk (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .req       (req),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .result    (result)
);

`default_nettype wire

/* verif/tb_wasm_fpu_f32.sv */
// Directed testbench for the f32 sign, compare and min/max unit
// Reference model and expected-result queue check every result in order

`default_nettype none
`timescale 1ns/100ps

module tb_wasm_fpu_f32;

    import wasm_f32_pkg::*;
    import wasm_fpu_pkg::*;

    localparam int WAIT_LIMIT = 200;

    logic     clk;
    logic     arst_n;
    logic     in_valid;
    logic     in_ready;
    fpu_req_t req;
    logic     out_valid;
    logic     out_ready;
    word_t    result;

    integer   seed;
    int       errors;
    int       total_sent;
    int       accepted;
    int       delivered;
    int       ready_idx;
    logic     ready_random;
    logic     stall_full;
    word_t    expected_word;
    logic     ready_pat [0:1023];
    word_t    exp_q [$];
    f32_t     special [0:11];

    wasm_fpu_f32 DUT (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .req       (req),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .result    (result)
    );

    always #20 clk = ~clk;

    function automatic logic nan_value(input f32_t x);
        return (x[30:23] == 8'hFF) && (x[22:0] != 23'd0);
    endfunction

    function automatic logic zero_value(input f32_t x);
        return x[30:0] == 31'd0;
    endfunction

    // Signed key that orders all non-NaN values, both zeros map to 0
    function automatic logic signed [31:0] order_key(input f32_t x);
        logic signed [31:0] mag;
        mag = $signed({1'b0, x[30:0]});
        return x[31] ? -mag : mag;
    endfunction

    function automatic logic less_than(input f32_t a, input f32_t b);
        return !nan_value(a) && !nan_value(b) && (order_key(a) < order_key(b));
    endfunction

    function automatic logic same_value(input f32_t a, input f32_t b);
        return !nan_value(a) && !nan_value(b) && (order_key(a) == order_key(b));
    endfunction

    function automatic word_t expected_result(input fpu_op_t op, input f32_t a, input f32_t b);
        logic nan_in;
        logic zeros;
        nan_in = nan_value(a) || nan_value(b);
        zeros  = zero_value(a) && zero_value(b);
        case (op)
            FPU_ABS:      return {1'b0, a[30:0]};
            FPU_NEG:      return a ^ 32'h8000_0000;
            FPU_COPYSIGN: return {b[31], a[30:0]};
            FPU_MIN:      return nan_in ? F32_CANONICAL_NAN :
                                 zeros ? (a[31] ? a : b) : (less_than(a, b) ? a : b);
            FPU_MAX:      return nan_in ? F32_CANONICAL_NAN :
                                 zeros ? (a[31] ? b : a) : (less_than(b, a) ? a : b);
            FPU_EQ:       return {31'd0, same_value(a, b)};
            FPU_NE:       return {31'd0, !same_value(a, b)};
            FPU_LT:       return {31'd0, less_than(a, b)};
            FPU_GT:       return {31'd0, less_than(b, a)};
            FPU_LE:       return {31'd0, less_than(a, b) || same_value(a, b)};
            FPU_GE:       return {31'd0, less_than(b, a) || same_value(a, b)};
            default:      return 32'd0;
        endcase
    endfunction

    // Mostly random bits, sometimes one of the special patterns
    function automatic f32_t random_operand();
        int r;
        r = $random(seed);
        return (r[2:0] < 3) ? special[r[11:8] % 12] : f32_t'($random(seed));
    endfunction

    task automatic finish_run();
        errors += DUT.u_chk.assert_errors;
        $display("errors: %0d  sent: %0d  accepted: %0d  delivered: %0d",
                 errors, total_sent, accepted, delivered);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    endtask

    task automatic abort_run(input string why);
        errors++;
        $display("ERROR: %s", why);
        finish_run();
    endtask

    // Called just after a rising edge, leaves in_valid high after acceptance
    task automatic send_req(input fpu_op_t op, input f32_t a, input f32_t b);
        int waited;
        waited   = 0;
        in_valid = 1'b1;
        req.op   = op;
        req.a    = a;
        req.b    = b;
        @(negedge clk);
        while (!in_ready && waited < WAIT_LIMIT) begin
            waited++;
            @(negedge clk);
        end
        if (!in_ready) begin
            abort_run("request was never accepted");
        end else begin
            exp_q.push_back(expected_result(op, a, b));
            total_sent++;
            @(posedge clk);
            #2;
        end
    endtask

    task automatic go_idle();
        in_valid = 1'b0;
        @(posedge clk);
        #2;
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < WAIT_LIMIT) begin
            waited++;
            @(posedge clk);
        end
        if (exp_q.size() != 0) begin
            abort_run("results still missing after the pipeline should have drained");
        end else begin
            @(posedge clk);
            #2;
        end
    endtask

    task automatic check_reset_latency();
        int edges;
        if (out_valid !== 1'b0) begin
            errors++;
            $display("FAIL out_valid: got %h expected 0", out_valid);
        end
        if (in_ready !== 1'b1) begin
            errors++;
            $display("FAIL in_ready: got %h expected 1", in_ready);
        end
        out_ready = 1'b1;
        send_req(FPU_NEG, 32'h3F80_0000, 32'h0000_0000);
        in_valid = 1'b0;
        // Cycles counted from the one in which the request was on the bus
        edges    = 1;
        @(negedge clk);
        while (!out_valid && edges < WAIT_LIMIT) begin
            edges++;
            @(negedge clk);
        end
        if (!out_valid) begin
            abort_run("out_valid never rose after the first request");
        end else if (edges != 2) begin
            errors++;
            $display("FAIL latency: got %h expected %h", edges, 2);
        end
        wait_drain();
    endtask

    task automatic sign_ops();
        for (int i = 0; i < 12; i++) begin
            send_req(FPU_ABS, special[i], special[11 - i]);
            send_req(FPU_NEG, special[i], special[11 - i]);
            send_req(FPU_COPYSIGN, special[i], special[(i + 5) % 12]);
        end
        go_idle();
        wait_drain();
    endtask

    // Every ordered pair of special patterns for each op in the range
    task automatic sweep_pairs(input int first_op, input int last_op);
        for (int k = first_op; k <= last_op; k++) begin
            for (int i = 0; i < 12; i++) begin
                for (int j = 0; j < 12; j++) begin
                    send_req(fpu_op_t'(k[3:0]), special[i], special[j]);
                end
            end
        end
        go_idle();
        wait_drain();
    endtask

    task automatic random_stream();
        f32_t a;
        f32_t b;
        int   r;
        for (int k = 0; k < 1024; k++) begin
            r            = $random(seed);
            ready_pat[k] = r[0];
        end
        ready_idx    = 0;
        ready_random = 1'b1;
        for (int n = 0; n < 200; n++) begin
            a = random_operand();
            r = $random(seed);
            // Equal operands now and then
            b = (r[1:0] == 2'd0) ? a : random_operand();
            send_req(fpu_op_t'(r[7:4]), a, b);
            if (r[11:9] == 3'd0) begin
                go_idle();
            end
        end
        go_idle();
        wait_drain();
        ready_random = 1'b0;
        out_ready    = 1'b1;
    endtask

    // Out_ready pattern replayed during the random stream
    always @(posedge clk) begin
        #2;
        if (ready_random) begin
            out_ready = ready_pat[ready_idx];
            ready_idx = (ready_idx + 1) % 1024;
        end
    end

    // Mid-cycle sampling, transfers counted here happen at the next rising edge
    always @(negedge clk) begin
        if (arst_n) begin
            // Two in flight means both registers hold a request
            stall_full = !out_ready && (accepted - delivered == 2);
            if (in_ready !== !stall_full) begin
                errors++;
                $display("FAIL in_ready: got %h expected %h", in_ready, !stall_full);
            end
            if (in_valid && in_ready) begin
                accepted++;
            end
            if (out_valid && out_ready) begin
                delivered++;
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("ERROR: a result was delivered with no request pending");
                end else begin
                    expected_word = exp_q.pop_front();
                    if (result !== expected_word) begin
                        errors++;
                        $display("FAIL result: got %08h expected %08h", result, expected_word);
                    end
                end
            end
        end
    end

    initial begin
        seed         = 45955;
        errors       = 0;
        total_sent   = 0;
        accepted     = 0;
        delivered    = 0;
        ready_idx    = 0;
        ready_random = 1'b0;
        clk          = 1'b0;
        arst_n       = 1'b0;
        in_valid     = 1'b0;
        req          = '0;
        out_ready    = 1'b0;
        // Zeros, ones, twos, infinities, NaNs with payloads, smallest subnormal
        special = '{32'h0000_0000, 32'h8000_0000, 32'h3F80_0000, 32'hBF80_0000,
                    32'h4000_0000, 32'hC000_0000, 32'h7F80_0000, 32'hFF80_0000,
                    32'h7FC0_0000, 32'h7FA1_2345, 32'hFFC0_0001, 32'h0000_0001};
        repeat (5) @(posedge clk);
        #2;
        arst_n = 1'b1;
        check_reset_latency();
        sign_ops();
        sweep_pairs(FPU_EQ, FPU_GE);
        sweep_pairs(FPU_MIN, FPU_MAX);
        random_stream();
        if (accepted != total_sent || delivered != total_sent) begin
            errors++;
            $display("ERROR: requests were lost or duplicated in the pipeline");
        end
        finish_run();
    end

endmodule

`default_nettype wire

/* src.f */
logic/wasm_f32_pkg.sv
logic/wasm_fpu_pkg.sv
logic/fpu_order_unit.sv
logic/fpu_issue_stage.sv
logic/fpu_exec_stage.sv
logic/wasm_fpu_f32.sv
verif/wasm_fpu_f32_chk.sv
verif/tb_wasm_fpu_f32.sv

/* Bender.yml */
package:
  name: wasm_fpu_f32

sources:
  - files:
      - logic/wasm_f32_pkg.sv
      - logic/wasm_fpu_pkg.sv
      - logic/fpu_order_unit.sv
      - logic/fpu_issue_stage.sv
      - logic/fpu_exec_stage.sv
      - logic/wasm_fpu_f32.sv
  - target: test
    files:
      - verif/wasm_fpu_f32_chk.sv
      - verif/tb_wasm_fpu_f32.sv
